// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = delay_path_tb
FILELIST  = delay_path.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== delay_path.f ====
hw/delay_pkg.sv
hw/delay_regs.sv
hw/delay_line.sv
hw/delay_out.sv
hw/delay_path.sv
sim/tb_clock.sv
sim/delay_path_checker.sv
sim/delay_path_tb.sv

// ==== hw/delay_line.sv ====
`timescale 1ns/100ps

module delay_line #(
   parameter int SAMPLE_WIDTH = 16,
   parameter int DEPTH_LOG2   = 5
) (
   input  logic                            ACLK,
   input  logic                            ARESETN,
   input  logic [SAMPLE_WIDTH-1:0]         sample_in,
   input  logic                            sample_in_valid,
   input  logic                            delay_enable,
   input  logic [delay_pkg::LEN_WIDTH-1:0] delay_length,
   input  logic                            host_reset,
   output logic [SAMPLE_WIDTH-1:0]         line_sample,
   output logic [SAMPLE_WIDTH-1:0]         line_delayed,
   output logic                            line_delayed_ok,
   output logic                            line_valid
);

   localparam int DEPTH = 1 << DEPTH_LOG2;
   localparam logic [DEPTH_LOG2-1:0] MAX_LEN = DEPTH_LOG2'(DEPTH - 1);

   logic [SAMPLE_WIDTH-1:0] ring [DEPTH];
   logic [DEPTH_LOG2-1:0]   wr_ptr;
   logic [DEPTH_LOG2-1:0]   rd_ptr;
   logic [DEPTH_LOG2-1:0]   fill;
   logic [DEPTH_LOG2-1:0]   len;
   logic                    store;

   // clamp length to 1 .. DEPTH-1
   always_comb begin
      if (delay_length == '0) begin
         len = DEPTH_LOG2'(1);
      end else if (delay_length > delay_pkg::LEN_WIDTH'(MAX_LEN)) begin
         len = MAX_LEN;
      end else begin
         len = delay_length[DEPTH_LOG2-1:0];
      end
   end

   assign rd_ptr = wr_ptr - len;
   assign store  = sample_in_valid && delay_enable && !host_reset;

   // write pointer and fill count
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_ptr <= '0;
         fill   <= '0;
      end else if (sample_in_valid && host_reset) begin
         fill <= '0;
      end else if (store) begin
         wr_ptr <= wr_ptr + 1'b1;
         // saturates, L never exceeds DEPTH-1
         if (fill != MAX_LEN) begin
            fill <= fill + 1'b1;
         end
      end
   end

   always_ff @(posedge ACLK) begin
      if (store) begin
         ring[wr_ptr] <= sample_in;
      end
   end

   // stage 1 output register, read happens before this write lands
   always_ff @(posedge ACLK) begin
      line_sample     <= sample_in;
      line_delayed    <= ring[rd_ptr];
      line_delayed_ok <= !host_reset && (fill >= len);
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         line_valid <= 1'b0;
      end else begin
         line_valid <= sample_in_valid;
      end
   end

endmodule

// ==== hw/delay_out.sv ====
`timescale 1ns/100ps

module delay_out #(
   parameter int SAMPLE_WIDTH = 16
) (
   input  logic                    ACLK,
   input  logic                    ARESETN,
   input  logic [SAMPLE_WIDTH-1:0] line_sample,
   input  logic [SAMPLE_WIDTH-1:0] line_delayed,
   input  logic                    line_delayed_ok,
   input  logic                    line_valid,
   input  logic                    delay_enable,
   input  logic                    delay_mux,
   output logic [SAMPLE_WIDTH-1:0] sample_out,
   output logic                    sample_out_valid
);

   logic                    enable_q;
   logic                    mux_q;
   logic [SAMPLE_WIDTH-1:0] selected;

   // controls captured with the sample as it enters stage 1
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         enable_q <= 1'b0;
         mux_q    <= 1'b0;
      end else begin
         enable_q <= delay_enable;
         mux_q    <= delay_mux;
      end
   end

   always_comb begin
      if (!mux_q) begin
         selected = line_sample;
      end else if (!enable_q || !line_delayed_ok) begin
         // muted, or line not yet filled
         selected = '0;
      end else begin
         selected = line_delayed;
      end
   end

   always_ff @(posedge ACLK) begin
      sample_out <= selected;
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         sample_out_valid <= 1'b0;
      end else begin
         sample_out_valid <= line_valid;
      end
   end

endmodule

// ==== hw/delay_path.sv ====
`timescale 1ns/100ps

module delay_path #(
   parameter int AXI_DATA_WIDTH = 32,
   parameter int AXI_ADDR_WIDTH = 32,
   parameter int SAMPLE_WIDTH   = 16,
   parameter int DEPTH_LOG2     = 5
) (
   input  logic                        ACLK,
   input  logic                        ARESETN,

   input  logic [AXI_ADDR_WIDTH-1:0]   AWADDR,
   input  logic                        AWVALID,
   output logic                        AWREADY,
   input  logic [AXI_DATA_WIDTH-1:0]   WDATA,
   input  logic [AXI_DATA_WIDTH/8-1:0] WSTRB,
   input  logic                        WVALID,
   output logic                        WREADY,
   output logic [1:0]                  BRESP,
   output logic                        BVALID,
   input  logic                        BREADY,
   input  logic [AXI_ADDR_WIDTH-1:0]   ARADDR,
   input  logic                        ARVALID,
   output logic                        ARREADY,
   output logic [AXI_DATA_WIDTH-1:0]   RDATA,
   output logic [1:0]                  RRESP,
   output logic                        RVALID,
   input  logic                        RREADY,

   input  logic [SAMPLE_WIDTH-1:0]     sample_in,
   input  logic                        sample_in_valid,
   output logic [SAMPLE_WIDTH-1:0]     sample_out,
   output logic                        sample_out_valid,
   output logic                        host_reset
);

   logic                            delay_enable;
   logic                            delay_mux;
   logic [delay_pkg::LEN_WIDTH-1:0] delay_length;
   logic [SAMPLE_WIDTH-1:0]         line_sample;
   logic [SAMPLE_WIDTH-1:0]         line_delayed;
   logic                            line_delayed_ok;
   logic                            line_valid;

   delay_regs #(
      .AXI_DATA_WIDTH (AXI_DATA_WIDTH),
      .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH)
   ) u_regs (
      .ACLK         (ACLK),
      .ARESETN      (ARESETN),
      .AWADDR       (AWADDR),
      .AWVALID      (AWVALID),
      .AWREADY      (AWREADY),
      .WDATA        (WDATA),
      .WSTRB        (WSTRB),
      .WVALID       (WVALID),
      .WREADY       (WREADY),
      .BRESP        (BRESP),
      .BVALID       (BVALID),
      .BREADY       (BREADY),
      .ARADDR       (ARADDR),
      .ARVALID      (ARVALID),
      .ARREADY      (ARREADY),
      .RDATA        (RDATA),
      .RRESP        (RRESP),
      .RVALID       (RVALID),
      .RREADY       (RREADY),
      .delay_enable (delay_enable),
      .delay_mux    (delay_mux),
      .delay_length (delay_length),
      .host_reset   (host_reset)
   );

   // stage 1
   delay_line #(
      .SAMPLE_WIDTH (SAMPLE_WIDTH),
      .DEPTH_LOG2   (DEPTH_LOG2)
   ) u_line (
      .ACLK            (ACLK),
      .ARESETN         (ARESETN),
      .sample_in       (sample_in),
      .sample_in_valid (sample_in_valid),
      .delay_enable    (delay_enable),
      .delay_length    (delay_length),
      .host_reset      (host_reset),
      .line_sample     (line_sample),
      .line_delayed    (line_delayed),
      .line_delayed_ok (line_delayed_ok),
      .line_valid      (line_valid)
   );

   // stage 2
   delay_out #(
      .SAMPLE_WIDTH (SAMPLE_WIDTH)
   ) u_out (
      .ACLK             (ACLK),
      .ARESETN          (ARESETN),
      .line_sample      (line_sample),
      .line_delayed     (line_delayed),
      .line_delayed_ok  (line_delayed_ok),
      .line_valid       (line_valid),
      .delay_enable     (delay_enable),
      .delay_mux        (delay_mux),
      .sample_out       (sample_out),
      .sample_out_valid (sample_out_valid)
   );

endmodule

// ==== hw/delay_pkg.sv ====
package delay_pkg;

   // register map, byte offsets in the low address byte
   localparam logic [7:0] REG_DELAY_ENABLE = 8'h00;
   localparam logic [7:0] REG_DELAY_MUX    = 8'h01;
   localparam logic [7:0] REG_DELAY_LENGTH = 8'h02;
   localparam logic [7:0] REG_HOST_RESET   = 8'h03;

   // AXI response codes
   localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
   localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

   // delay length register width
   localparam int LEN_WIDTH = 32;

endpackage

// ==== hw/delay_regs.sv ====
`timescale 1ns/100ps

module delay_regs #(
   parameter int AXI_DATA_WIDTH = 32,
   parameter int AXI_ADDR_WIDTH = 32
) (
   input  logic                          ACLK,
   input  logic                          ARESETN,

   input  logic [AXI_ADDR_WIDTH-1:0]     AWADDR,
   input  logic                          AWVALID,
   output logic                          AWREADY,

   input  logic [AXI_DATA_WIDTH-1:0]     WDATA,
   input  logic [AXI_DATA_WIDTH/8-1:0]   WSTRB,
   input  logic                          WVALID,
   output logic                          WREADY,

   output logic [1:0]                    BRESP,
   output logic                          BVALID,
   input  logic                          BREADY,

   input  logic [AXI_ADDR_WIDTH-1:0]     ARADDR,
   input  logic                          ARVALID,
   output logic                          ARREADY,

   output logic [AXI_DATA_WIDTH-1:0]     RDATA,
   output logic [1:0]                    RRESP,
   output logic                          RVALID,
   input  logic                          RREADY,

   output logic                          delay_enable,
   output logic                          delay_mux,
   output logic [delay_pkg::LEN_WIDTH-1:0] delay_length,
   output logic                          host_reset
);

   localparam logic [1:0] WR_IDLE = 2'd0;
   localparam logic [1:0] WR_DATA = 2'd1;
   localparam logic [1:0] WR_RESP = 2'd2;

   localparam logic RD_IDLE = 1'b0;
   localparam logic RD_RESP = 1'b1;

   logic [1:0]                wr_state;
   logic [7:0]                wr_addr;
   logic                      wr_fire;
   logic                      wr_mapped;

   logic                      rd_state;
   logic                      rd_fire;
   logic [AXI_DATA_WIDTH-1:0] rd_data_next;
   logic [1:0]                rd_resp_next;

   assign AWREADY = (wr_state == WR_IDLE);
   assign WREADY  = (wr_state == WR_DATA);
   assign BVALID  = (wr_state == WR_RESP);

   assign ARREADY = (rd_state == RD_IDLE);
   assign RVALID  = (rd_state == RD_RESP);

   assign wr_fire   = WREADY && WVALID;
   assign wr_mapped = (wr_addr <= delay_pkg::REG_HOST_RESET);
   assign rd_fire   = ARREADY && ARVALID;

   // write channel FSM
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_state <= WR_IDLE;
         wr_addr  <= '0;
      end else begin
         case (wr_state)
            WR_IDLE: begin
               if (AWVALID) begin
                  wr_addr  <= AWADDR[7:0];
                  wr_state <= WR_DATA;
               end
            end
            WR_DATA: begin
               if (WVALID) begin
                  wr_state <= WR_RESP;
               end
            end
            WR_RESP: begin
               if (BREADY) begin
                  wr_state <= WR_IDLE;
               end
            end
            default: wr_state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge ACLK) begin
      if (wr_fire) begin
         BRESP <= wr_mapped ? delay_pkg::AXI_RESP_OKAY : delay_pkg::AXI_RESP_SLVERR;
      end
   end

   // control registers, written on the W handshake
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         delay_enable <= 1'b0;
         delay_mux    <= 1'b0;
         delay_length <= '0;
         host_reset   <= 1'b0;
      end else if (wr_fire) begin
         case (wr_addr)
            delay_pkg::REG_DELAY_ENABLE: begin
               if (WSTRB[0]) begin
                  delay_enable <= WDATA[0];
               end
            end
            delay_pkg::REG_DELAY_MUX: begin
               if (WSTRB[0]) begin
                  delay_mux <= WDATA[0];
               end
            end
            delay_pkg::REG_DELAY_LENGTH: begin
               // only the strobed byte lanes change
               for (int i = 0; i < delay_pkg::LEN_WIDTH / 8; i++) begin
                  if (WSTRB[i]) begin
                     delay_length[8*i +: 8] <= WDATA[8*i +: 8];
                  end
               end
            end
            delay_pkg::REG_HOST_RESET: begin
               if (WSTRB[0]) begin
                  host_reset <= WDATA[0];
               end
            end
            default: begin
            end
         endcase
      end
   end

   // read decode, sampled at AR acceptance
   always_comb begin
      rd_data_next = '0;
      rd_resp_next = delay_pkg::AXI_RESP_OKAY;
      case (ARADDR[7:0])
         delay_pkg::REG_DELAY_ENABLE: rd_data_next[0] = delay_enable;
         delay_pkg::REG_DELAY_MUX:    rd_data_next[0] = delay_mux;
         delay_pkg::REG_DELAY_LENGTH: rd_data_next = AXI_DATA_WIDTH'(delay_length);
         delay_pkg::REG_HOST_RESET:   rd_data_next[0] = host_reset;
         default:                     rd_resp_next = delay_pkg::AXI_RESP_SLVERR;
      endcase
   end

   // read channel FSM
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         rd_state <= RD_IDLE;
      end else begin
         case (rd_state)
            RD_IDLE: begin
               if (ARVALID) begin
                  rd_state <= RD_RESP;
               end
            end
            RD_RESP: begin
               if (RREADY) begin
                  rd_state <= RD_IDLE;
               end
            end
            default: rd_state <= RD_IDLE;
         endcase
      end
   end

   // held stable until RREADY
   always_ff @(posedge ACLK) begin
      if (rd_fire) begin
         RDATA <= rd_data_next;
         RRESP <= rd_resp_next;
      end
   end

endmodule

// ==== sim/delay_path_checker.sv ====
`timescale 1ns/100ps

module delay_path_checker #(
   parameter int DATA_WIDTH = 32
) (
   input logic                  ACLK,
   input logic                  ARESETN,
   input logic                  WREADY,
   input logic                  BVALID,
   input logic                  BREADY,
   input logic                  RVALID,
   input logic                  RREADY,
   input logic [DATA_WIDTH-1:0] RDATA,
   input logic [1:0]            RRESP,
   input logic                  sample_in_valid,
   input logic                  sample_out_valid
);

   bvalid_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
      BVALID && !BREADY |=> BVALID)
      else $error("BVALID dropped before BREADY");

   rvalid_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
      RVALID && !RREADY |=> RVALID)
      else $error("RVALID dropped before RREADY");

   // read payload frozen while stalled
   rdata_stable: assert property (@(posedge ACLK) disable iff (!ARESETN)
      RVALID && !RREADY |=> $stable(RDATA) && $stable(RRESP))
      else $error("RDATA or RRESP changed during a read stall");

   out_valid_delay: assert property (@(posedge ACLK) disable iff (!ARESETN)
      sample_out_valid == $past(sample_in_valid, 2))
      else $error("sample_out_valid is not sample_in_valid delayed by two cycles");

   no_wready_with_bvalid: assert property (@(posedge ACLK) disable iff (!ARESETN)
      !(WREADY && BVALID))
      else $error("WREADY and BVALID high together");

endmodule

bind delay_path delay_path_checker #(
   .DATA_WIDTH (AXI_DATA_WIDTH)
) u_checker (
   .ACLK             (ACLK),
   .ARESETN          (ARESETN),
   .WREADY           (WREADY),
   .BVALID           (BVALID),
   .BREADY           (BREADY),
   .RVALID           (RVALID),
   .RREADY           (RREADY),
   .RDATA            (RDATA),
   .RRESP            (RRESP),
   .sample_in_valid  (sample_in_valid),
   .sample_out_valid (sample_out_valid)
);

// ==== sim/delay_path_tb.sv ====
`timescale 1ns/100ps

module delay_path_tb;

   localparam int AW         = 32;
   localparam int DW         = 32;
   localparam int SW         = 16;
   localparam int DEPTH_LOG2 = 5;
   localparam int MAX_LEN    = (1 << DEPTH_LOG2) - 1;
   localparam int TIMEOUT    = 200;
   localparam int STIM_LEN   = 1024;

   logic            ACLK;
   logic            ARESETN;
   logic [AW-1:0]   AWADDR;
   logic            AWVALID;
   logic            AWREADY;
   logic [DW-1:0]   WDATA;
   logic [DW/8-1:0] WSTRB;
   logic            WVALID;
   logic            WREADY;
   logic [1:0]      BRESP;
   logic            BVALID;
   logic            BREADY;
   logic [AW-1:0]   ARADDR;
   logic            ARVALID;
   logic            ARREADY;
   logic [DW-1:0]   RDATA;
   logic [1:0]      RRESP;
   logic            RVALID;
   logic            RREADY;
   logic [SW-1:0]   sample_in;
   logic            sample_in_valid;
   logic [SW-1:0]   sample_out;
   logic            sample_out_valid;
   logic            host_reset;

   integer          seed;
   string           test_name;
   logic [SW-1:0]   stim_data [STIM_LEN];
   logic            stim_valid [STIM_LEN];
   int              stim_idx;
   logic            stream_on;
   logic            model_on;

   // reference copies of the registers and the stored samples
   logic            m_enable;
   logic            m_mux;
   logic            m_host_reset;
   logic [31:0]     m_length;
   logic [SW-1:0]   fill_q [$];
   logic [SW-1:0]   exp_data [2];
   logic            exp_valid [2];

   tb_clock #(
      .PERIOD (4.0)
   ) u_clock (
      .clk (ACLK)
   );

   delay_path #(
      .AXI_DATA_WIDTH (DW),
      .AXI_ADDR_WIDTH (AW),
      .SAMPLE_WIDTH   (SW),
      .DEPTH_LOG2     (DEPTH_LOG2)
   ) dut (
      .ACLK             (ACLK),
      .ARESETN          (ARESETN),
      .AWADDR           (AWADDR),
      .AWVALID          (AWVALID),
      .AWREADY          (AWREADY),
      .WDATA            (WDATA),
      .WSTRB            (WSTRB),
      .WVALID           (WVALID),
      .WREADY           (WREADY),
      .BRESP            (BRESP),
      .BVALID           (BVALID),
      .BREADY           (BREADY),
      .ARADDR           (ARADDR),
      .ARVALID          (ARVALID),
      .ARREADY          (ARREADY),
      .RDATA            (RDATA),
      .RRESP            (RRESP),
      .RVALID           (RVALID),
      .RREADY           (RREADY),
      .sample_in        (sample_in),
      .sample_in_valid  (sample_in_valid),
      .sample_out       (sample_out),
      .sample_out_valid (sample_out_valid),
      .host_reset       (host_reset)
   );

   task automatic check_value(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Mismatch in %s (%s): expected %0h, actual %0h",
                  test_name, label, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout in %s while waiting for %s", test_name, what);
      $display("TEST FAILED");
      $fatal(1, "handshake timeout");
   endtask

   function automatic int clamp_len(input logic [31:0] length);
      if (length == 32'd0) begin
         return 1;
      end
      if (length > 32'(MAX_LEN)) begin
         return MAX_LEN;
      end
      return int'(length);
   endfunction

   function automatic logic [31:0] reg_value(input logic [7:0] offset);
      case (offset)
         delay_pkg::REG_DELAY_ENABLE: return {31'd0, m_enable};
         delay_pkg::REG_DELAY_MUX:    return {31'd0, m_mux};
         delay_pkg::REG_DELAY_LENGTH: return m_length;
         delay_pkg::REG_HOST_RESET:   return {31'd0, m_host_reset};
         default:                     return 32'd0;
      endcase
   endfunction

   task automatic update_model(input logic [7:0] offset, input logic [31:0] data,
                               input logic [3:0] strb);
      case (offset)
         delay_pkg::REG_DELAY_ENABLE: if (strb[0]) m_enable = data[0];
         delay_pkg::REG_DELAY_MUX:    if (strb[0]) m_mux = data[0];
         delay_pkg::REG_HOST_RESET:   if (strb[0]) m_host_reset = data[0];
         delay_pkg::REG_DELAY_LENGTH: begin
            for (int i = 0; i < 4; i++) begin
               if (strb[i]) begin
                  m_length[8*i +: 8] = data[8*i +: 8];
               end
            end
         end
         default: begin
         end
      endcase
   endtask

   // starts and ends one time unit after a rising edge
   task automatic write_reg(input logic [7:0] offset, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
      logic [31:0] upper;
      int          count;
      int          stall;
      upper   = $random(seed);
      AWADDR  = {upper[31:8], offset};
      AWVALID = 1'b1;
      WDATA   = data;
      WSTRB   = strb;
      WVALID  = 1'b1;
      count   = 0;
      do begin
         @(negedge ACLK);
         count++;
         if (count > TIMEOUT) report_timeout("AWREADY");
      end while (!AWREADY);
      @(posedge ACLK);
      #1;
      AWVALID = 1'b0;
      count   = 0;
      do begin
         @(negedge ACLK);
         count++;
         if (count > TIMEOUT) report_timeout("WREADY");
      end while (!WREADY);
      @(posedge ACLK);
      #1;
      WVALID = 1'b0;
      update_model(offset, data, strb);
      count = 0;
      do begin
         @(negedge ACLK);
         count++;
         if (count > TIMEOUT) report_timeout("BVALID");
      end while (!BVALID);
      stall = $random(seed) & 3;
      repeat (stall) @(negedge ACLK);
      @(posedge ACLK);
      #1;
      BREADY = 1'b1;
      @(negedge ACLK);
      resp = BRESP;
      @(posedge ACLK);
      #1;
      BREADY = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] offset, output logic [31:0] data,
                           output logic [1:0] resp);
      logic [31:0] upper;
      int          count;
      int          stall;
      upper   = $random(seed);
      ARADDR  = {upper[31:8], offset};
      ARVALID = 1'b1;
      count   = 0;
      do begin
         @(negedge ACLK);
         count++;
         if (count > TIMEOUT) report_timeout("ARREADY");
      end while (!ARREADY);
      @(posedge ACLK);
      #1;
      ARVALID = 1'b0;
      count   = 0;
      do begin
         @(negedge ACLK);
         count++;
         if (count > TIMEOUT) report_timeout("RVALID");
      end while (!RVALID);
      stall = $random(seed) & 3;
      repeat (stall) @(negedge ACLK);
      @(posedge ACLK);
      #1;
      RREADY = 1'b1;
      @(negedge ACLK);
      data = RDATA;
      resp = RRESP;
      @(posedge ACLK);
      #1;
      RREADY = 1'b0;
   endtask

   task automatic set_reg(input logic [7:0] offset, input logic [31:0] data);
      logic [1:0] resp;
      write_reg(offset, data, 4'hf, resp);
      check_value("write response", 32'(delay_pkg::AXI_RESP_OKAY), 32'(resp));
   endtask

   task automatic readback_all;
      logic [31:0] data;
      logic [1:0]  resp;
      for (int r = 0; r < 4; r++) begin
         read_reg(8'(r), data, resp);
         check_value("read response", 32'(delay_pkg::AXI_RESP_OKAY), 32'(resp));
         check_value("read data", reg_value(8'(r)), data);
      end
   endtask

   task automatic run_cycles(input int n);
      repeat (n) @(posedge ACLK);
      #1;
   endtask

   // stream source from the pre-drawn table
   always @(posedge ACLK) begin
      #1;
      if (stream_on) begin
         sample_in       = stim_data[stim_idx];
         sample_in_valid = stim_valid[stim_idx];
         stim_idx        = (stim_idx + 1) % STIM_LEN;
      end else begin
         sample_in_valid = 1'b0;
      end
   end

   // reference model sees what the DUT samples at the next rising edge
   always @(negedge ACLK) begin
      logic [SW-1:0] delayed;
      int            len;
      if (model_on) begin
         check_value("output valid", 32'(exp_valid[1]), 32'(sample_out_valid));
         if (exp_valid[1]) begin
            check_value("output sample", 32'(exp_data[1]), 32'(sample_out));
         end
         check_value("host_reset port", 32'(m_host_reset), 32'(host_reset));
         len = clamp_len(m_length);
         if (sample_in_valid && m_host_reset) begin
            fill_q.delete();
         end
         delayed = '0;
         if (!m_host_reset && fill_q.size() >= len) begin
            delayed = fill_q[fill_q.size() - len];
         end
         exp_data[1]  = exp_data[0];
         exp_valid[1] = exp_valid[0];
         exp_valid[0] = sample_in_valid;
         if (!m_mux) begin
            exp_data[0] = sample_in;
         end else if (!m_enable) begin
            exp_data[0] = '0;
         end else begin
            exp_data[0] = delayed;
         end
         if (sample_in_valid && m_enable && !m_host_reset) begin
            fill_q.push_back(sample_in);
            if (fill_q.size() > MAX_LEN) begin
               void'(fill_q.pop_front());
            end
         end
      end
   end

   initial begin
      logic [31:0] data;
      logic [1:0]  resp;
      logic [7:0]  offset;
      logic [3:0]  strb;
      seed            = 15307;
      test_name       = "reset";
      ARESETN         = 1'b0;
      AWADDR          = '0;
      AWVALID         = 1'b0;
      WDATA           = '0;
      WSTRB           = '0;
      WVALID          = 1'b0;
      BREADY          = 1'b0;
      ARADDR          = '0;
      ARVALID         = 1'b0;
      RREADY          = 1'b0;
      sample_in       = '0;
      sample_in_valid = 1'b0;
      stim_idx        = 0;
      stream_on       = 1'b0;
      model_on        = 1'b0;
      m_enable        = 1'b0;
      m_mux           = 1'b0;
      m_host_reset    = 1'b0;
      m_length        = '0;
      exp_data[0]     = '0;
      exp_data[1]     = '0;
      exp_valid[0]    = 1'b0;
      exp_valid[1]    = 1'b0;
      for (int i = 0; i < STIM_LEN; i++) begin
         stim_data[i]  = 16'($random(seed));
         stim_valid[i] = (($random(seed) & 3) != 0);
      end

      repeat (8) @(posedge ACLK);
      #1;
      ARESETN   = 1'b1;
      model_on  = 1'b1;
      stream_on = 1'b1;
      readback_all();

      test_name = "register access";
      for (int n = 0; n < 8; n++) begin
         for (int r = 0; r < 4; r++) begin
            set_reg(8'(r), $random(seed));
         end
         readback_all();
      end
      for (int n = 0; n < 12; n++) begin
         strb = 4'($random(seed));
         write_reg(delay_pkg::REG_DELAY_LENGTH, $random(seed), strb, resp);
         check_value("strobe write response", 32'(delay_pkg::AXI_RESP_OKAY), 32'(resp));
         read_reg(delay_pkg::REG_DELAY_LENGTH, data, resp);
         check_value("strobe readback", reg_value(delay_pkg::REG_DELAY_LENGTH), data);
      end

      test_name = "unmapped offset";
      for (int n = 0; n < 8; n++) begin
         offset = 8'($random(seed));
         if (offset < 8'd4) begin
            offset = offset + 8'd4;
         end
         write_reg(offset, $random(seed), 4'hf, resp);
         check_value("write response", 32'(delay_pkg::AXI_RESP_SLVERR), 32'(resp));
         read_reg(offset, data, resp);
         check_value("read response", 32'(delay_pkg::AXI_RESP_SLVERR), 32'(resp));
         readback_all();
      end

      test_name = "bypass";
      set_reg(delay_pkg::REG_HOST_RESET, 32'd0);
      set_reg(delay_pkg::REG_DELAY_MUX, 32'd0);
      run_cycles(200);

      test_name = "mute";
      set_reg(delay_pkg::REG_DELAY_ENABLE, 32'd0);
      set_reg(delay_pkg::REG_DELAY_MUX, 32'd1);
      run_cycles(200);

      test_name = "delay";
      set_reg(delay_pkg::REG_HOST_RESET, 32'd1);
      set_reg(delay_pkg::REG_HOST_RESET, 32'd0);
      set_reg(delay_pkg::REG_DELAY_ENABLE, 32'd1);
      // zero and oversize lengths hit the clamp
      set_reg(delay_pkg::REG_DELAY_LENGTH, 32'd0);
      run_cycles(80);
      set_reg(delay_pkg::REG_DELAY_LENGTH, 32'd31);
      run_cycles(120);
      set_reg(delay_pkg::REG_DELAY_LENGTH, 32'd32);
      run_cycles(80);
      set_reg(delay_pkg::REG_DELAY_LENGTH, 32'h0001_0005);
      run_cycles(80);
      for (int n = 0; n < 10; n++) begin
         set_reg(delay_pkg::REG_DELAY_LENGTH, 32'($random(seed) & 63));
         run_cycles(60);
      end

      test_name = "host reset";
      set_reg(delay_pkg::REG_DELAY_LENGTH, 32'd20);
      set_reg(delay_pkg::REG_HOST_RESET, 32'd1);
      check_value("host_reset high", 32'd1, 32'(host_reset));
      run_cycles(50);
      set_reg(delay_pkg::REG_HOST_RESET, 32'd0);
      check_value("host_reset low", 32'd0, 32'(host_reset));
      run_cycles(150);

      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
   parameter real PERIOD = 4.0
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2.0) clk = ~clk;
   end

endmodule
